// File: hdl/snn_pkg.sv
// ----------------------------------------------------------
// shared sizes, register map, reset defaults and bus/config
// structs for the snn inference core; import where needed
// ----------------------------------------------------------
`default_nettype none

package snn_pkg;

  // datapath sizes
  localparam int ADC_CHANNELS       = 20;
  localparam int ADC_BITS           = 8;
  localparam int NUM_OUTPUTS        = 10;
  localparam int NEURON_DATA_WIDTH  = 9;
  localparam int MEMBRANE_WIDTH     = 20;
  localparam int RESULT_WIDTH       = 4;
  localparam int RESULT_FIFO_DEPTH  = 4;
  localparam int RESULT_COUNT_WIDTH = $clog2(RESULT_FIFO_DEPTH + 1);
  localparam int CH_SEL_WIDTH       = $clog2(ADC_CHANNELS);
  // one spike per step at most, so 8 bits covers 255 steps
  localparam int SPIKE_WIDTH        = 8;
  localparam int COUNTER_WIDTH      = 16;

  // saturation limits and reset defaults
  localparam logic [ADC_BITS-1:0] ADC_SAT_HIGH      = 8'hF0;
  localparam logic [ADC_BITS-1:0] ADC_SAT_LOW       = 8'h0F;
  localparam logic [15:0]         THRESHOLD_DEFAULT = 16'd200;
  localparam logic [7:0]          TIMESTEPS_DEFAULT = 8'd10;

  // ----------------------------------------------------------
  // register byte offsets
  // ----------------------------------------------------------
  localparam logic [7:0] REG_CTRL           = 8'h00;
  localparam logic [7:0] REG_STATUS         = 8'h04;
  localparam logic [7:0] REG_THRESHOLD      = 8'h08;
  localparam logic [7:0] REG_TIMESTEPS      = 8'h0C;
  localparam logic [7:0] REG_RESULT         = 8'h10;
  localparam logic [7:0] REG_RESULT_COUNT   = 8'h14;
  localparam logic [7:0] REG_ADC_SAT        = 8'h18;
  localparam logic [7:0] REG_RESULT_CNT     = 8'h1C;
  localparam logic [7:0] REG_TEST_DATA_BASE = 8'h40;

  // one-cycle register bus request
  typedef struct packed {
    logic        valid;
    logic        write;
    logic [7:0]  addr;
    logic [31:0] wdata;
  } bus_req_t;

  // inference configuration, held as levels
  typedef struct packed {
    logic [15:0] threshold;
    logic [7:0]  timesteps;
    logic        reset_mode;
  } snn_cfg_t;

  // per-neuron scheme b differences, each signed
  typedef struct packed {
    logic [NUM_OUTPUTS-1:0][NEURON_DATA_WIDTH-1:0] diff;
  } neuron_vec_t;

endpackage

`default_nettype wire

// File: hdl/snn_reg_bank.sv
// ----------------------------------------------------------
// register block on the simple bus: control strobes, config,
// status, counters, result pop and the fake adc byte table
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module snn_reg_bank
  import snn_pkg::*;
(
  input  wire logic                          clk,
  input  wire logic                          rst_n,
  input  wire bus_req_t                      bus_req,
  input  wire logic                          busy,
  input  wire logic                          done_pulse,
  input  wire logic [CH_SEL_WIDTH-1:0]       bl_sel,
  input  wire logic [COUNTER_WIDTH-1:0]      sat_high,
  input  wire logic [COUNTER_WIDTH-1:0]      sat_low,
  input  wire logic [RESULT_WIDTH-1:0]       result_head,
  input  wire logic [RESULT_COUNT_WIDTH-1:0] result_count,
  input  wire logic                          result_empty,
  input  wire logic                          result_push,
  output logic [31:0]                        rdata,
  output logic                               rvalid,
  output snn_cfg_t                           cfg,
  output logic                               start_pulse,
  output logic                               soft_reset_pulse,
  output logic [ADC_BITS-1:0]                bl_data,
  output logic                               result_pop
);

  logic                     wr_en;
  logic                     rd_en;
  logic                     tbl_hit;
  logic [7:0]               tbl_off;
  logic [CH_SEL_WIDTH-1:0]  tbl_idx;
  logic                     done_seen;
  logic [COUNTER_WIDTH-1:0] push_cnt;
  logic [31:0]              rd_mux;
  logic [ADC_BITS-1:0]      adc_table [ADC_CHANNELS];

  assign wr_en = bus_req.valid & bus_req.write;
  assign rd_en = bus_req.valid & ~bus_req.write;

  // table window starts at the base, one word per channel
  assign tbl_off = bus_req.addr - REG_TEST_DATA_BASE;
  assign tbl_idx = tbl_off[CH_SEL_WIDTH+1:2];
  assign tbl_hit = (bus_req.addr >= REG_TEST_DATA_BASE) &&
                   (tbl_off[7:2] < 6'(ADC_CHANNELS));

  // fake adc response for the channel under scan
  assign bl_data = adc_table[bl_sel];

  // pop only when a head entry exists
  assign result_pop = rd_en && (bus_req.addr == REG_RESULT) && !result_empty;

  // ----------------------------------------------------------
  // config, strobes, status and counters
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg.threshold    <= THRESHOLD_DEFAULT;
      cfg.timesteps    <= TIMESTEPS_DEFAULT;
      cfg.reset_mode   <= 1'b0;
      start_pulse      <= 1'b0;
      soft_reset_pulse <= 1'b0;
      done_seen        <= 1'b0;
      push_cnt         <= '0;
      rvalid           <= 1'b0;
    end else begin
      start_pulse      <= 1'b0;
      soft_reset_pulse <= 1'b0;
      rvalid           <= rd_en;
      if (wr_en) begin
        case (bus_req.addr)
          REG_CTRL: begin
            start_pulse      <= bus_req.wdata[0];
            soft_reset_pulse <= bus_req.wdata[1];
            cfg.reset_mode   <= bus_req.wdata[2];
          end
          REG_THRESHOLD: cfg.threshold <= bus_req.wdata[15:0];
          REG_TIMESTEPS: cfg.timesteps <= bus_req.wdata[7:0];
          default: ;
        endcase
      end
      // sticky until the next accepted start
      if (done_pulse) begin
        done_seen <= 1'b1;
      end else if (start_pulse && !busy) begin
        done_seen <= 1'b0;
      end
      if (result_push && !(&push_cnt)) begin
        push_cnt <= push_cnt + 1'b1;
      end
    end
  end

  // fake adc table
  always_ff @(posedge clk) begin
    if (wr_en && tbl_hit) begin
      adc_table[tbl_idx] <= bus_req.wdata[ADC_BITS-1:0];
    end
  end

  // ----------------------------------------------------------
  // read mux, returned one cycle after the request
  // ----------------------------------------------------------
  always_comb begin
    rd_mux = '0;
    case (bus_req.addr)
      REG_CTRL:         rd_mux[2] = cfg.reset_mode;
      REG_STATUS:       rd_mux[1:0] = {done_seen, busy};
      REG_THRESHOLD:    rd_mux = 32'(cfg.threshold);
      REG_TIMESTEPS:    rd_mux = 32'(cfg.timesteps);
      REG_RESULT: begin
        rd_mux    = 32'(result_head);
        rd_mux[8] = result_empty;
      end
      REG_RESULT_COUNT: rd_mux = 32'(result_count);
      REG_ADC_SAT:      rd_mux = {sat_high, sat_low};
      REG_RESULT_CNT:   rd_mux = 32'(push_cnt);
      default: begin
        if (tbl_hit) begin
          rd_mux = 32'(adc_table[tbl_idx]);
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rdata <= rd_mux;
    end
  end

endmodule

`default_nettype wire

// File: hdl/snn_seq_ctrl.sv
// ----------------------------------------------------------
// timestep sequencer: kicks one adc scan per step, flags the
// final step and pulses done once it has been integrated
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module snn_seq_ctrl
  import snn_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     rst_n,
  input  wire logic     start_pulse,
  input  wire logic     soft_reset_pulse,
  input  wire snn_cfg_t cfg,
  input  wire logic     neuron_in_valid,
  output logic          adc_kick_pulse,
  output logic          last_step,
  output logic          busy,
  output logic          done_pulse
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_STEP,
    S_WAIT
  } state_t;

  state_t     state;
  logic [7:0] step_cnt;
  logic [7:0] last_idx;

  // zero timesteps still runs a single step
  assign last_idx = (cfg.timesteps == 8'd0) ? 8'd0 : cfg.timesteps - 8'd1;

  assign busy           = (state != S_IDLE);
  assign adc_kick_pulse = (state == S_STEP);
  assign last_step      = busy && (step_cnt == last_idx);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= S_IDLE;
      step_cnt   <= 8'd0;
      done_pulse <= 1'b0;
    end else begin
      done_pulse <= 1'b0;
      if (soft_reset_pulse) begin
        state    <= S_IDLE;
        step_cnt <= 8'd0;
      end else begin
        case (state)
          S_IDLE: begin
            // start while busy never reaches here
            if (start_pulse) begin
              state    <= S_STEP;
              step_cnt <= 8'd0;
            end
          end
          S_STEP: state <= S_WAIT;
          S_WAIT: begin
            if (neuron_in_valid) begin
              if (last_step) begin
                state      <= S_IDLE;
                done_pulse <= 1'b1;
              end else begin
                state    <= S_STEP;
                step_cnt <= step_cnt + 8'd1;
              end
            end
          end
          default: state <= S_IDLE;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/adc_scan.sv
// ----------------------------------------------------------
// bit-line scanner with the fake one-cycle adc: two cycles per
// channel, even minus odd per pair, saturation counting
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module adc_scan
  import snn_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  adc_kick_pulse,
  input  wire logic [ADC_BITS-1:0]   bl_data,
  output logic [CH_SEL_WIDTH-1:0]    bl_sel,
  output logic                       neuron_in_valid,
  output neuron_vec_t                neuron_in_data,
  output logic [COUNTER_WIDTH-1:0]   sat_high,
  output logic [COUNTER_WIDTH-1:0]   sat_low
);

  logic                running;
  logic                adc_start;
  logic                adc_done;
  logic                last_ch;
  logic [ADC_BITS-1:0] pos_sample;

  // kick launches channel 0 in the same cycle
  assign adc_start = adc_kick_pulse | (running & ~adc_done);
  assign last_ch   = (bl_sel == CH_SEL_WIDTH'(ADC_CHANNELS - 1));

  // ----------------------------------------------------------
  // scan control and fake adc response
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      running         <= 1'b0;
      adc_done        <= 1'b0;
      bl_sel          <= '0;
      neuron_in_valid <= 1'b0;
    end else begin
      // response one cycle after start
      adc_done        <= adc_start;
      neuron_in_valid <= 1'b0;
      if (adc_kick_pulse) begin
        running <= 1'b1;
        bl_sel  <= '0;
      end else if (adc_done && running) begin
        if (last_ch) begin
          running         <= 1'b0;
          bl_sel          <= '0;
          neuron_in_valid <= 1'b1;
        end else begin
          bl_sel <= bl_sel + 1'b1;
        end
      end
    end
  end

  // scheme b: even sample positive, odd sample negative
  always_ff @(posedge clk) begin
    if (adc_done && running && !adc_kick_pulse) begin
      if (!bl_sel[0]) begin
        pos_sample <= bl_data;
      end else begin
        neuron_in_data.diff[bl_sel[CH_SEL_WIDTH-1:1]] <=
          {1'b0, pos_sample} - {1'b0, bl_data};
      end
    end
  end

  // ----------------------------------------------------------
  // saturating sample counters, rst_n only
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sat_high <= '0;
      sat_low  <= '0;
    end else if (adc_done && running && !adc_kick_pulse) begin
      if ((bl_data >= ADC_SAT_HIGH) && !(&sat_high)) begin
        sat_high <= sat_high + 1'b1;
      end
      if ((bl_data <= ADC_SAT_LOW) && !(&sat_low)) begin
        sat_low <= sat_low + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/lif_array.sv
// ----------------------------------------------------------
// ten lif neurons: integrate, fire, reset, count spikes and
// push the winning class index after the final step
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module lif_array
  import snn_pkg::*;
(
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire logic               soft_reset_pulse,
  input  wire snn_cfg_t           cfg,
  input  wire logic               neuron_in_valid,
  input  wire neuron_vec_t        neuron_in_data,
  input  wire logic               last_step,
  input  wire logic               result_full,
  output logic                    result_push,
  output logic [RESULT_WIDTH-1:0] result_class
);

  logic signed [MEMBRANE_WIDTH-1:0] membrane  [NUM_OUTPUTS];
  logic signed [MEMBRANE_WIDTH-1:0] mem_sum   [NUM_OUTPUTS];
  logic signed [MEMBRANE_WIDTH-1:0] mem_nxt   [NUM_OUTPUTS];
  logic        [SPIKE_WIDTH-1:0]    spike_cnt [NUM_OUTPUTS];
  logic        [SPIKE_WIDTH-1:0]    cnt_nxt   [NUM_OUTPUTS];
  logic signed [MEMBRANE_WIDTH-1:0] thr;
  logic        [SPIKE_WIDTH-1:0]    best_cnt;
  logic        [RESULT_WIDTH-1:0]   winner;

  // unsigned threshold, zero extended into the membrane range
  assign thr = $signed(MEMBRANE_WIDTH'(cfg.threshold));

  // ----------------------------------------------------------
  // next membranes and spike counts for this step
  // ----------------------------------------------------------
  always_comb begin
    for (int i = 0; i < NUM_OUTPUTS; i++) begin
      mem_sum[i] = membrane[i] +
                   MEMBRANE_WIDTH'($signed(neuron_in_data.diff[i]));
      if (mem_sum[i] >= thr) begin
        // subtractive reset keeps the overshoot
        mem_nxt[i] = cfg.reset_mode ? '0 : mem_sum[i] - thr;
        cnt_nxt[i] = spike_cnt[i] + 1'b1;
      end else begin
        mem_nxt[i] = mem_sum[i];
        cnt_nxt[i] = spike_cnt[i];
      end
    end
  end

  // most spikes wins, strict compare keeps the lowest index
  always_comb begin
    best_cnt = cnt_nxt[0];
    winner   = '0;
    for (int i = 1; i < NUM_OUTPUTS; i++) begin
      if (cnt_nxt[i] > best_cnt) begin
        best_cnt = cnt_nxt[i];
        winner   = RESULT_WIDTH'(i);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result_push <= 1'b0;
      for (int i = 0; i < NUM_OUTPUTS; i++) begin
        membrane[i]  <= '0;
        spike_cnt[i] <= '0;
      end
    end else begin
      result_push <= 1'b0;
      if (soft_reset_pulse) begin
        for (int i = 0; i < NUM_OUTPUTS; i++) begin
          membrane[i]  <= '0;
          spike_cnt[i] <= '0;
        end
      end else if (neuron_in_valid) begin
        // full fifo drops the result
        result_push <= last_step && !result_full;
        for (int i = 0; i < NUM_OUTPUTS; i++) begin
          membrane[i]  <= last_step ? '0 : mem_nxt[i];
          spike_cnt[i] <= last_step ? '0 : cnt_nxt[i];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (neuron_in_valid && last_step) begin
      result_class <= winner;
    end
  end

endmodule

`default_nettype wire

// File: hdl/result_fifo.sv
// ----------------------------------------------------------
// synchronous circular fifo for class results; head is shown
// combinationally, pushes while full are dropped
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module result_fifo
  import snn_pkg::*;
#(
  parameter int DEPTH = 4
) (
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  input  wire logic                       push,
  input  wire logic [RESULT_WIDTH-1:0]    push_data,
  input  wire logic                       pop,
  output logic [RESULT_WIDTH-1:0]         head,
  output logic [$clog2(DEPTH+1)-1:0]      count,
  output logic                            empty,
  output logic                            full
);

  localparam int PW = $clog2(DEPTH);

  logic [RESULT_WIDTH-1:0] mem [DEPTH];
  logic [PW-1:0]           wr_ptr;
  logic [PW-1:0]           rd_ptr;
  logic                    do_push;
  logic                    do_pop;

  assign empty   = (count == '0);
  assign full    = (count == ($clog2(DEPTH+1))'(DEPTH));
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  assign head    = mem[rd_ptr];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves the count alone
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

endmodule

`default_nettype wire

// File: hdl/snn_core_top.sv
// ----------------------------------------------------------
// snn inference core top: register bank, sequencer, adc scan,
// lif array and result fifo on one register bus
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module snn_core_top
  import snn_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     rst_n,
  input  wire bus_req_t bus_req,
  output logic [31:0]   rdata,
  output logic          rvalid
);

  // control plane
  snn_cfg_t                    cfg;
  logic                        start_pulse;
  logic                        soft_reset_pulse;
  logic                        busy;
  logic                        done_pulse;
  logic                        adc_kick_pulse;
  logic                        last_step;

  // scan and neuron datapath
  logic [CH_SEL_WIDTH-1:0]     bl_sel;
  logic [ADC_BITS-1:0]         bl_data;
  logic                        neuron_in_valid;
  neuron_vec_t                 neuron_in_data;
  logic [COUNTER_WIDTH-1:0]    sat_high;
  logic [COUNTER_WIDTH-1:0]    sat_low;

  // result path
  logic                        result_push;
  logic [RESULT_WIDTH-1:0]     result_class;
  logic                        result_pop;
  logic [RESULT_WIDTH-1:0]     result_head;
  logic [RESULT_COUNT_WIDTH-1:0] result_count;
  logic                        result_empty;
  logic                        result_full;

  snn_reg_bank i_snn_reg_bank (
    .clk              (clk),
    .rst_n            (rst_n),
    .bus_req          (bus_req),
    .busy             (busy),
    .done_pulse       (done_pulse),
    .bl_sel           (bl_sel),
    .sat_high         (sat_high),
    .sat_low          (sat_low),
    .result_head      (result_head),
    .result_count     (result_count),
    .result_empty     (result_empty),
    .result_push      (result_push),
    .rdata            (rdata),
    .rvalid           (rvalid),
    .cfg              (cfg),
    .start_pulse      (start_pulse),
    .soft_reset_pulse (soft_reset_pulse),
    .bl_data          (bl_data),
    .result_pop       (result_pop)
  );

  snn_seq_ctrl i_snn_seq_ctrl (
    .clk              (clk),
    .rst_n            (rst_n),
    .start_pulse      (start_pulse),
    .soft_reset_pulse (soft_reset_pulse),
    .cfg              (cfg),
    .neuron_in_valid  (neuron_in_valid),
    .adc_kick_pulse   (adc_kick_pulse),
    .last_step        (last_step),
    .busy             (busy),
    .done_pulse       (done_pulse)
  );

  adc_scan i_adc_scan (
    .clk              (clk),
    .rst_n            (rst_n),
    .adc_kick_pulse   (adc_kick_pulse),
    .bl_data          (bl_data),
    .bl_sel           (bl_sel),
    .neuron_in_valid  (neuron_in_valid),
    .neuron_in_data   (neuron_in_data),
    .sat_high         (sat_high),
    .sat_low          (sat_low)
  );

  lif_array i_lif_array (
    .clk              (clk),
    .rst_n            (rst_n),
    .soft_reset_pulse (soft_reset_pulse),
    .cfg              (cfg),
    .neuron_in_valid  (neuron_in_valid),
    .neuron_in_data   (neuron_in_data),
    .last_step        (last_step),
    .result_full      (result_full),
    .result_push      (result_push),
    .result_class     (result_class)
  );

  result_fifo #(
    .DEPTH (RESULT_FIFO_DEPTH)
  ) i_result_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (result_push),
    .push_data (result_class),
    .pop       (result_pop),
    .head      (result_head),
    .count     (result_count),
    .empty     (result_empty),
    .full      (result_full)
  );

endmodule

`default_nettype wire

// File: verif/tb_snn_core.sv
// ----------------------------------------------------------
// testbench for the snn core driving a row table over the
// register bus and checking winners against a lif model
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_snn_core
  import snn_pkg::*;
();

  localparam int          READ_TIMEOUT = 16;
  localparam int          DONE_POLLS   = 4000;
  localparam int          BUSY_POLLS   = 64;
  localparam int          NUM_ROWS     = 6;
  localparam int          NUM_QUEUED   = 5;
  localparam logic [31:0] SEED         = 32'h2b86f9af;

  typedef enum logic [1:0] {
    FILL_RANDOM,
    FILL_SAT_HIGH,
    FILL_SAT_LOW
  } fill_t;

  // one stimulus row
  typedef struct packed {
    logic [15:0] threshold;
    logic [7:0]  timesteps;
    logic        reset_mode;
    fill_t       style;
  } row_t;

  logic        clk;
  logic        rst_n;
  bus_req_t    bus_req;
  logic [31:0] rdata;
  logic        rvalid;

  row_t        rows [NUM_ROWS];
  logic [7:0]  tbl [ADC_CHANNELS];
  int          errors;
  int          timeouts;
  // expected saturation counts accumulated over all runs
  int          exp_high;
  int          exp_low;

  snn_core_top i_snn_core_top (
    .clk     (clk),
    .rst_n   (rst_n),
    .bus_req (bus_req),
    .rdata   (rdata),
    .rvalid  (rvalid)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ----------------------------------------------------------
  // reporting
  // ----------------------------------------------------------
  task automatic finish_run();
    $display("closing: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  endtask

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Error at %0t ns: %s = 0x%0h, expected 0x%0h",
               $time, name, actual, expected);
      errors++;
    end
  endtask

  // ----------------------------------------------------------
  // one-cycle bus access
  // ----------------------------------------------------------
  task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk);
    bus_req <= '{valid: 1'b1, write: 1'b1, addr: addr, wdata: data};
    @(posedge clk);
    bus_req <= '0;
  endtask

  task automatic bus_read(input logic [7:0] addr, output logic [31:0] data);
    int waited;
    waited = 0;
    data   = '0;
    @(posedge clk);
    bus_req <= '{valid: 1'b1, write: 1'b0, addr: addr, wdata: 32'd0};
    @(posedge clk);
    bus_req <= '0;
    // rvalid and rdata settle by the falling edge
    @(negedge clk);
    while (!rvalid && waited < READ_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (rvalid) begin
      data = rdata;
    end else begin
      $display("timeout: no read response from address 0x%0h", addr);
      timeouts++;
      finish_run();
    end
  endtask

  task automatic read_check(input logic [7:0] addr, input string name,
                            input logic [31:0] expected);
    logic [31:0] value;
    bus_read(addr, value);
    check(name, value, expected);
  endtask

  // poll one status bit until it is set
  task automatic wait_status(input int bit_idx, input int max_polls,
                             input string what);
    logic [31:0] st;
    int          polls;
    st    = '0;
    polls = 0;
    while (!st[bit_idx] && polls < max_polls) begin
      bus_read(REG_STATUS, st);
      polls++;
    end
    if (!st[bit_idx]) begin
      $display("timeout: status never showed %s", what);
      timeouts++;
      finish_run();
    end
  endtask

  // ----------------------------------------------------------
  // reference model
  // ----------------------------------------------------------
  function automatic int model_winner(input int thr, input int ts, input logic mode);
    int diff [NUM_OUTPUTS];
    int mem  [NUM_OUTPUTS];
    int cnt  [NUM_OUTPUTS];
    int steps;
    int best;
    steps = (ts == 0) ? 1 : ts;
    // even channel minus odd channel per neuron
    for (int n = 0; n < NUM_OUTPUTS; n++) begin
      diff[n] = int'(tbl[2 * n]) - int'(tbl[2 * n + 1]);
      mem[n]  = 0;
      cnt[n]  = 0;
    end
    for (int s = 0; s < steps; s++) begin
      for (int n = 0; n < NUM_OUTPUTS; n++) begin
        mem[n] = mem[n] + diff[n];
        if (mem[n] >= thr) begin
          cnt[n]++;
          mem[n] = mode ? 0 : mem[n] - thr;
        end
      end
    end
    // ties keep the lower index
    best = 0;
    for (int n = 1; n < NUM_OUTPUTS; n++) begin
      if (cnt[n] > cnt[best]) begin
        best = n;
      end
    end
    return best;
  endfunction

  // saturating samples in one scan
  function automatic int sat_samples(input logic high);
    int n;
    n = 0;
    for (int ch = 0; ch < ADC_CHANNELS; ch++) begin
      if (high && tbl[ch] >= ADC_SAT_HIGH) begin
        n++;
      end
      if (!high && tbl[ch] <= ADC_SAT_LOW) begin
        n++;
      end
    end
    return n;
  endfunction

  // ----------------------------------------------------------
  // stimulus helpers
  // ----------------------------------------------------------
  task automatic load_table(input fill_t style);
    logic [31:0] r;
    for (int ch = 0; ch < ADC_CHANNELS; ch++) begin
      r = $urandom;
      case (style)
        // even channels pinned high
        FILL_SAT_HIGH: tbl[ch] = (ch % 2 == 0) ? (8'hF0 | {4'h0, r[3:0]}) : r[7:0];
        // odd channels pinned low
        FILL_SAT_LOW:  tbl[ch] = (ch % 2 == 1) ? {4'h0, r[3:0]} : r[7:0];
        default:       tbl[ch] = r[7:0];
      endcase
      bus_write(REG_TEST_DATA_BASE + 8'(4 * ch), {24'd0, tbl[ch]});
    end
  endtask

  task automatic start_run(input logic [15:0] thr, input logic [7:0] ts,
                           input logic mode);
    int steps;
    steps = (ts == 8'd0) ? 1 : int'(ts);
    bus_write(REG_THRESHOLD, {16'd0, thr});
    bus_write(REG_TIMESTEPS, {24'd0, ts});
    bus_write(REG_CTRL, {29'd0, mode, 2'b01});
    exp_high += steps * sat_samples(1'b1);
    exp_low  += steps * sat_samples(1'b0);
  endtask

  task automatic check_sat();
    read_check(REG_ADC_SAT, "adc_sat", {exp_high[15:0], exp_low[15:0]});
  endtask

  // ----------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------
  initial begin
    logic [31:0] rd;
    logic [31:0] pushed;
    int          winners [NUM_QUEUED];
    errors   = 0;
    timeouts = 0;
    exp_high = 0;
    exp_low  = 0;
    bus_req  = '0;
    rst_n    = 1'b0;
    rd       = $urandom(SEED);

    rows[0] = '{threshold: 16'd200, timesteps: 8'd10, reset_mode: 1'b0, style: FILL_RANDOM};
    rows[1] = '{threshold: 16'd200, timesteps: 8'd10, reset_mode: 1'b1, style: FILL_RANDOM};
    rows[2] = '{threshold: 16'd150, timesteps: 8'd8, reset_mode: 1'b0, style: FILL_SAT_HIGH};
    rows[3] = '{threshold: 16'd300, timesteps: 8'd12, reset_mode: 1'b1, style: FILL_SAT_LOW};
    rows[4] = '{threshold: 16'd100, timesteps: 8'd0, reset_mode: 1'b0, style: FILL_RANDOM};
    rows[5] = '{threshold: 16'd250, timesteps: 8'd6, reset_mode: 1'b1, style: FILL_SAT_HIGH};

    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    // defaults after reset and register readback
    read_check(REG_THRESHOLD, "threshold", 32'(THRESHOLD_DEFAULT));
    read_check(REG_TIMESTEPS, "timesteps", 32'(TIMESTEPS_DEFAULT));
    read_check(REG_STATUS, "status", 32'd0);
    read_check(REG_RESULT_COUNT, "result_count", 32'd0);
    bus_read(REG_RESULT, rd);
    check("result_empty", {31'd0, rd[8]}, 32'd1);
    bus_write(REG_THRESHOLD, 32'h0000_1234);
    read_check(REG_THRESHOLD, "threshold", 32'h0000_1234);
    bus_write(REG_TIMESTEPS, 32'h0000_005A);
    read_check(REG_TIMESTEPS, "timesteps", 32'h0000_005A);
    bus_write(REG_CTRL, 32'h0000_0004);
    read_check(REG_CTRL, "ctrl", 32'h0000_0004);
    bus_write(REG_CTRL, 32'h0000_0000);
    load_table(FILL_RANDOM);
    for (int ch = 0; ch < ADC_CHANNELS; ch++) begin
      read_check(REG_TEST_DATA_BASE + 8'(4 * ch), $sformatf("adc_table[%0d]", ch),
                 {24'd0, tbl[ch]});
    end

    // one popped result per table row
    for (int r = 0; r < NUM_ROWS; r++) begin
      load_table(rows[r].style);
      start_run(rows[r].threshold, rows[r].timesteps, rows[r].reset_mode);
      wait_status(1, DONE_POLLS, "done");
      read_check(REG_STATUS, "status", 32'd2);
      read_check(REG_RESULT, $sformatf("row %0d result", r),
                 32'(model_winner(int'(rows[r].threshold), int'(rows[r].timesteps),
                                  rows[r].reset_mode)));
      check_sat();
    end

    // fifo fills at four and drops the fifth result
    bus_read(REG_RESULT_CNT, pushed);
    for (int k = 0; k < NUM_QUEUED; k++) begin
      load_table(FILL_RANDOM);
      winners[k] = model_winner(200, 4, 1'(k % 2));
      start_run(16'd200, 8'd4, 1'(k % 2));
      wait_status(1, DONE_POLLS, "done");
    end
    read_check(REG_RESULT_COUNT, "result_count", 32'(RESULT_FIFO_DEPTH));
    read_check(REG_RESULT_CNT, "result_cnt", pushed + 32'(RESULT_FIFO_DEPTH));
    for (int k = 0; k < RESULT_FIFO_DEPTH; k++) begin
      read_check(REG_RESULT, $sformatf("queued result %0d", k), 32'(winners[k]));
    end
    bus_read(REG_RESULT, rd);
    check("result_empty", {31'd0, rd[8]}, 32'd1);
    check_sat();

    // soft reset in the middle of an inference
    load_table(FILL_RANDOM);
    bus_read(REG_RESULT_CNT, pushed);
    start_run(16'd200, 8'd10, 1'b0);
    wait_status(0, BUSY_POLLS, "busy");
    bus_write(REG_CTRL, 32'h0000_0002);
    read_check(REG_STATUS, "status", 32'd0);
    // let the scan in flight run out at two cycles per channel
    repeat (2 * ADC_CHANNELS + 8) @(posedge clk);
    // drop the pair it integrated on the way out
    bus_write(REG_CTRL, 32'h0000_0002);
    read_check(REG_RESULT_COUNT, "result_count", 32'd0);
    read_check(REG_RESULT_CNT, "result_cnt", pushed);
    // the aborted run only finished its first scan
    exp_high -= (10 - 1) * sat_samples(1'b1);
    exp_low  -= (10 - 1) * sat_samples(1'b0);
    check_sat();
    start_run(16'd200, 8'd10, 1'b1);
    wait_status(1, DONE_POLLS, "done");
    read_check(REG_RESULT, "result after soft reset", 32'(model_winner(200, 10, 1'b1)));
    read_check(REG_RESULT_CNT, "result_cnt", pushed + 32'd1);
    check_sat();

    finish_run();
  end

endmodule

`default_nettype wire

// File: list.f
hdl/snn_pkg.sv
hdl/snn_reg_bank.sv
hdl/snn_seq_ctrl.sv
hdl/adc_scan.sv
hdl/lif_array.sv
hdl/result_fifo.sv
hdl/snn_core_top.sv
verif/tb_snn_core.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the snn core testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module tb_snn_core -o tb_snn_core

sim_out=$(./obj_dir/tb_snn_core)
echo "$sim_out"

if grep -qF '*** PASSED ***' <<< "$sim_out"; then
  exit 0
fi
exit 1
